/* flist.f */
+incdir+tb
src/core_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_unit.sv
src/control_logic.sv
src/execute_unit.sv
src/rv_core.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* tb/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

    // RV32I major opcodes
    localparam logic [6:0]  LUI_OPC     = 7'b0110111;
    localparam logic [6:0]  AUIPC_OPC   = 7'b0010111;
    localparam logic [6:0]  JAL_OPC     = 7'b1101111;
    localparam logic [6:0]  JALR_OPC    = 7'b1100111;
    localparam logic [6:0]  BRANCH_OPC  = 7'b1100011;
    localparam logic [6:0]  IMM_OPC     = 7'b0010011;
    localparam logic [6:0]  REG_OPC     = 7'b0110011;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // Markers written on each program path
    localparam logic [11:0] TAKEN_MARK     = 12'h7a1;
    localparam logic [11:0] NOT_TAKEN_MARK = 12'h3b5;
    localparam logic [11:0] JUMP_MARK      = 12'h5a5;
    localparam logic [11:0] SKIP_MARK      = 12'h111;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, REG_OPC};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Offsets are byte offsets, bit 0 is dropped by the format
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH_OPC};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL_OPC};
    endfunction

    // Unused words hold addi x0 with the byte address as immediate
    function automatic logic [31:0] fill_word(input int idx);
        return enc_i(12'(idx * 4), 5'd0, 3'd0, 5'd0, IMM_OPC);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // LUI plus ADDI, the 0x800 rounds for the sign of the low part
    task automatic emit_li(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;
        emit(enc_u(hi[31:12], rd, LUI_OPC));
        emit(enc_i(val[11:0], rd, 3'd0, rd, IMM_OPC));
    endtask

    // Branch at 16 skips to 28 when taken, ebreak at 32
    task automatic build_branch_prog(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        emit(enc_b(13'd12, 5'd2, 5'd1, f3));
        emit(enc_i(NOT_TAKEN_MARK, 5'd0, 3'd0, 5'd1, IMM_OPC));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(TAKEN_MARK, 5'd0, 3'd0, 5'd1, IMM_OPC));
        emit(EBREAK_WORD);
    endtask

    // JAL to 12, then JALR to 29 + 4 which lands on 32
    task automatic build_jump_prog;
        emit(enc_j(21'd12, 5'd1));
        emit(enc_i(SKIP_MARK, 5'd0, 3'd0, 5'd2, IMM_OPC));
        emit(EBREAK_WORD);
        emit(enc_i(JUMP_MARK, 5'd0, 3'd0, 5'd2, IMM_OPC));
        emit(enc_i(12'd29, 5'd0, 3'd0, 5'd3, IMM_OPC));
        emit(enc_i(12'd4, 5'd3, 3'd0, 5'd3, JALR_OPC));
        emit(enc_i(SKIP_MARK, 5'd0, 3'd0, 5'd2, IMM_OPC));
        emit(EBREAK_WORD);
        emit(EBREAK_WORD);
    endtask

    // Writes to x0, then add x3 = x0 + x0, ebreak at 16
    task automatic build_x0_prog;
        emit(enc_i(12'h055, 5'd0, 3'd0, 5'd3, IMM_OPC));
        emit(enc_u(20'habcde, 5'd0, LUI_OPC));
        emit(enc_i(12'h123, 5'd0, 3'd0, 5'd0, IMM_OPC));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd3));
        emit(EBREAK_WORD);
    endtask

    // Endless counter loop between 4 and 8
    task automatic build_loop_prog;
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd1, IMM_OPC));
        emit(enc_i(12'd1, 5'd1, 3'd0, 5'd1, IMM_OPC));
        emit(enc_j(21'h1ffffc, 5'd0));
    endtask

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int          CLK_PERIOD   = 40;
    localparam int          MEM_WORDS    = 64;
    localparam int          HALT_TIMEOUT = 200;
    localparam int          HOLD_CYCLES  = 6;
    localparam logic [31:0] SEED         = 32'hb5f9706b;

    localparam logic [2:0] RR_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam bit         RR_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                           1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic        clk;
    logic        reset_i;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] pc;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic        halted;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] prog [$];

    // Expected values and the strobes that enable their checks
    logic        chk_x1;
    logic        chk_x2;
    logic        chk_x3;
    logic        chk_pc;
    logic        chk_halt;
    logic [31:0] exp_x1;
    logic [31:0] exp_x2;
    logic [31:0] exp_x3;
    logic [31:0] exp_pc;
    logic        exp_halted;

    int error_count;
    int test_count;
    bit timed_out;

    `include "tb_programs.svh"

    rv_core UUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .pc_o         (pc),
        .x1_o         (x1),
        .x2_o         (x2),
        .x3_o         (x3),
        .halted_o     (halted)
    );

    // Word-addressed instruction memory with no wait states
    assign imem_rdata = imem[imem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    x1_check_a: assert property (@(posedge clk) chk_x1 |-> x1 == exp_x1)
        else begin
            $display("CHECK FAILED x1_o: got %h, expected %h", $sampled(x1), $sampled(exp_x1));
            error_count++;
        end

    x2_check_a: assert property (@(posedge clk) chk_x2 |-> x2 == exp_x2)
        else begin
            $display("CHECK FAILED x2_o: got %h, expected %h", $sampled(x2), $sampled(exp_x2));
            error_count++;
        end

    x3_check_a: assert property (@(posedge clk) chk_x3 |-> x3 == exp_x3)
        else begin
            $display("CHECK FAILED x3_o: got %h, expected %h", $sampled(x3), $sampled(exp_x3));
            error_count++;
        end

    pc_check_a: assert property (@(posedge clk) chk_pc |-> pc == exp_pc)
        else begin
            $display("CHECK FAILED pc_o: got %h, expected %h", $sampled(pc), $sampled(exp_pc));
            error_count++;
        end

    addr_check_a: assert property (@(posedge clk) chk_pc |-> imem_addr == exp_pc)
        else begin
            $display("CHECK FAILED imem_addr_o: got %h, expected %h",
                     $sampled(imem_addr), $sampled(exp_pc));
            error_count++;
        end

    halt_check_a: assert property (@(posedge clk) chk_halt |-> halted == exp_halted)
        else begin
            $display("CHECK FAILED halted_o: got %h, expected %h",
                     $sampled(halted), $sampled(exp_halted));
            error_count++;
        end

    // RV32I result for OP and OP-IMM by funct3 with alt as funct7 bit 5
    function automatic logic [31:0] isa_result(input logic [2:0] f3, input bit alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic start_program;
        @(posedge clk);
        #1;
        reset_i = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
        end
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: %s did not reach ebreak within %0d cycles", name, HALT_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // Run the loaded program to ebreak, then hold the checks for several cycles
    task automatic run_test(input string name, input bit c1, input bit c2, input bit c3,
                            input logic [31:0] e1, input logic [31:0] e2,
                            input logic [31:0] e3, input logic [31:0] ep);
        int errors_before;
        if (timed_out) begin
            return;
        end
        errors_before = error_count;
        start_program();
        wait_for_halt(name);
        if (timed_out) begin
            return;
        end
        exp_x1     = e1;
        exp_x2     = e2;
        exp_x3     = e3;
        exp_pc     = ep;
        exp_halted = 1'b1;
        chk_x1     = c1;
        chk_x2     = c2;
        chk_x3     = c3;
        chk_pc     = 1'b1;
        chk_halt   = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        #1;
        {chk_x1, chk_x2, chk_x3, chk_pc, chk_halt} = '0;
        test_count++;
        $display("%-16s %s", name, (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    // Operands go to x1 and x2 with the instruction under test at 16 and ebreak at 20
    task automatic run_alu_case(input string name, input logic [31:0] a,
                                input logic [31:0] b, input logic [31:0] word,
                                input logic [31:0] expected);
        prog.delete();
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        emit(word);
        emit(EBREAK_WORD);
        run_test(name, 1'b1, 1'b1, 1'b1, a, b, expected, 32'd20);
    endtask

    task automatic run_rtype_tests;
        string       names [10];
        logic [31:0] a;
        logic [31:0] b;
        names = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or", "and"};
        for (int k = 0; k < 10; k++) begin
            a = $urandom;
            b = $urandom;
            run_alu_case(names[k], a, b,
                         enc_r(RR_ALT[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, RR_F3[k], 5'd3),
                         isa_result(RR_F3[k], RR_ALT[k], a, b));
        end
    endtask

    task automatic run_imm_tests;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = $urandom;
        b = $urandom;
        r = $urandom;
        run_alu_case("addi", a, b, enc_i(r[11:0], 5'd1, 3'd0, 5'd3, IMM_OPC),
                     isa_result(3'd0, 1'b0, a, sext12(r[11:0])));
        r = $urandom;
        run_alu_case("slti", a, b, enc_i(r[11:0], 5'd1, 3'd2, 5'd3, IMM_OPC),
                     isa_result(3'd2, 1'b0, a, sext12(r[11:0])));
        r = $urandom;
        run_alu_case("xori", a, b, enc_i(r[11:0], 5'd1, 3'd4, 5'd3, IMM_OPC),
                     isa_result(3'd4, 1'b0, a, sext12(r[11:0])));
        // Negative operand so the sign fill shows
        a = $urandom;
        a = a | 32'h8000_0000;
        r = $urandom;
        run_alu_case("srai", a, b, enc_i({7'h20, r[4:0]}, 5'd1, 3'd5, 5'd3, IMM_OPC),
                     isa_result(3'd5, 1'b1, a, {27'b0, r[4:0]}));
        r = $urandom;
        run_alu_case("lui", a, b, enc_u(r[31:12], 5'd3, LUI_OPC), {r[31:12], 12'h000});
        r = $urandom;
        run_alu_case("auipc", a, b, enc_u(r[31:12], 5'd3, AUIPC_OPC),
                     32'd16 + {r[31:12], 12'h000});
    endtask

    task automatic run_branch_tests;
        string       names [6];
        logic [31:0] a;
        logic [31:0] b;
        bit          want;
        bit          taken;
        names = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        for (int k = 0; k < 6; k++) begin
            for (int t = 0; t < 2; t++) begin
                want = (t == 0);
                a    = $urandom;
                b    = $urandom;
                if (BR_F3[k][2] == 1'b0) begin
                    // Equality kinds need equal operands on one of the paths
                    if ((BR_F3[k][0] == 1'b0) == want) begin
                        b = a;
                    end else if (b == a) begin
                        b = ~a;
                    end
                end else begin
                    if (b == a) begin
                        b = a ^ 32'h1;
                    end
                    if (branch_rule(BR_F3[k], a, b) != want) begin
                        {a, b} = {b, a};
                    end
                end
                taken = branch_rule(BR_F3[k], a, b);
                prog.delete();
                build_branch_prog(BR_F3[k], a, b);
                run_test(want ? {names[k], " taken"} : {names[k], " not taken"},
                         1'b1, 1'b1, 1'b0,
                         {20'b0, taken ? TAKEN_MARK : NOT_TAKEN_MARK}, b, 32'd0, 32'd32);
            end
        end
    endtask

    task automatic run_reset_test;
        int errors_before;
        if (timed_out) begin
            return;
        end
        errors_before = error_count;
        prog.delete();
        build_loop_prog();
        start_program();
        repeat (7) @(posedge clk);
        #1;
        assert (!halted && pc != 32'd0)
            else begin
                $display("Loop program was not running before the mid-run reset");
                error_count++;
            end
        reset_i = 1'b1;
        @(posedge clk);
        #1;
        exp_pc     = 32'd0;
        exp_halted = 1'b0;
        chk_pc     = 1'b1;
        chk_halt   = 1'b1;
        @(posedge clk);
        #1;
        chk_pc   = 1'b0;
        chk_halt = 1'b0;
        reset_i  = 1'b0;
        test_count++;
        $display("%-16s %s", "reset mid-run", (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        reset_i     = 1'b1;
        {chk_x1, chk_x2, chk_x3, chk_pc, chk_halt} = '0;
        exp_x1      = '0;
        exp_x2      = '0;
        exp_x3      = '0;
        exp_pc      = '0;
        exp_halted  = 1'b0;
        error_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = fill_word(i);
        end
        void'($urandom(SEED));

        run_rtype_tests();
        run_imm_tests();
        run_branch_tests();
        prog.delete();
        build_jump_prog();
        run_test("jal jalr", 1'b1, 1'b1, 1'b1, 32'd4, {20'b0, JUMP_MARK}, 32'd24, 32'd32);
        prog.delete();
        build_x0_prog();
        run_test("x0 and halt", 1'b0, 1'b0, 1'b1, 32'd0, 32'd0, 32'd0, 32'd16);
        run_reset_test();

        $display("%0d tests run, %0d errors, timeout %0d", test_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core import core_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    output xlen_t imem_addr_o,
    input  inst_t imem_rdata_i,
    output xlen_t pc_o,
    output xlen_t x1_o,
    output xlen_t x2_o,
    output xlen_t x3_o,
    output logic  halted_o
);

    xlen_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     br_target;
    xlen_t     jal_target;
    xlen_t     jalr_target;
    logic      br_eq;
    logic      br_lt;
    logic      br_ltu;
    alu_op_t   alu_op;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    pc_sel_t   pc_sel;
    wb_sel_t   wb_sel;
    logic      rf_we;
    logic      halt_req;
    xlen_t     wb_data;

    assign imem_addr_o = pc;
    assign pc_o        = pc;

    fetch_unit u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_sel_i      (pc_sel),
        .br_target_i   (br_target),
        .jal_target_i  (jal_target),
        .jalr_target_i (jalr_target),
        .halt_req_i    (halt_req),
        .pc_o          (pc),
        .halted_o      (halted_o)
    );

    register_file u_regfile (
        .clk        (clk),
        .we_i       (rf_we),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .wd_i       (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .x1_o       (x1_o),
        .x2_o       (x2_o),
        .x3_o       (x3_o)
    );

    decode_unit u_decode (
        .inst_i        (imem_rdata_i),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .op1_sel_i     (op1_sel),
        .op2_sel_i     (op2_sel),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .br_target_o   (br_target),
        .jal_target_o  (jal_target),
        .jalr_target_o (jalr_target),
        .br_eq_o       (br_eq),
        .br_lt_o       (br_lt),
        .br_ltu_o      (br_ltu)
    );

    control_logic u_control (
        .inst_i     (imem_rdata_i),
        .br_eq_i    (br_eq),
        .br_lt_i    (br_lt),
        .br_ltu_i   (br_ltu),
        .alu_op_o   (alu_op),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .pc_sel_o   (pc_sel),
        .wb_sel_o   (wb_sel),
        .rf_we_o    (rf_we),
        .halt_req_o (halt_req)
    );

    execute_unit u_execute (
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .pc_i      (pc),
        .alu_op_i  (alu_op),
        .wb_sel_i  (wb_sel),
        .wb_data_o (wb_data)
    );

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  xlen_t   op_a_i,
    input  xlen_t   op_b_i,
    input  xlen_t   pc_i,
    input  alu_op_t alu_op_i,
    input  wb_sel_t wb_sel_i,
    output xlen_t   wb_data_o
);

    xlen_t      alu_res;
    xlen_t      pc_plus4;
    logic [4:0] shamt;

    assign shamt    = op_b_i[4:0];
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = op_a_i - op_b_i;
            ALU_SLL:    alu_res = op_a_i << shamt;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
            ALU_XOR:    alu_res = op_a_i ^ op_b_i;
            ALU_SRL:    alu_res = op_a_i >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(op_a_i) >>> shamt);
            ALU_OR:     alu_res = op_a_i | op_b_i;
            ALU_AND:    alu_res = op_a_i & op_b_i;
            ALU_PASS_B: alu_res = op_b_i;
            default:    alu_res = op_a_i + op_b_i;
        endcase
    end

    // Link value for JAL and JALR
    assign wb_data_o = (wb_sel_i == WB_PC4) ? pc_plus4 : alu_res;

endmodule

`default_nettype wire

/* src/control_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module control_logic import core_pkg::*; (
    input  inst_t    inst_i,
    input  logic     br_eq_i,
    input  logic     br_lt_i,
    input  logic     br_ltu_i,
    output alu_op_t  alu_op_o,
    output op1_sel_t op1_sel_o,
    output op2_sel_t op2_sel_o,
    output pc_sel_t  pc_sel_o,
    output wb_sel_t  wb_sel_o,
    output logic     rf_we_o,
    output logic     halt_req_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    logic       br_taken;
    alu_op_t    arith_op;

    assign opcode   = opcode_t'(inst_i[6:0]);
    assign funct3   = inst_i[14:12];
    assign funct7_5 = inst_i[30];

    // Branch outcome from funct3, 010 and 011 are reserved and fall through
    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_eq_i;
            3'b001:  br_taken = !br_eq_i;
            3'b100:  br_taken = br_lt_i;
            3'b101:  br_taken = !br_lt_i;
            3'b110:  br_taken = br_ltu_i;
            3'b111:  br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    // ALU op for OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000: begin
                // SUB exists only in the register form
                if (opcode == OPC_OP && funct7_5) begin
                    arith_op = ALU_SUB;
                end else begin
                    arith_op = ALU_ADD;
                end
            end
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o  = ALU_ADD;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        pc_sel_o  = PC_PLUS4;
        wb_sel_o  = WB_ALU;
        rf_we_o   = 1'b0;

        case (opcode)
            OPC_LUI: begin
                alu_op_o  = ALU_PASS_B;
                op1_sel_o = OP1_ZERO;
                op2_sel_o = OP2_IMM_U;
                rf_we_o   = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_U;
                rf_we_o   = 1'b1;
            end
            OPC_JAL: begin
                pc_sel_o = PC_JAL;
                wb_sel_o = WB_PC4;
                rf_we_o  = 1'b1;
            end
            OPC_JALR: begin
                pc_sel_o = PC_JALR;
                wb_sel_o = WB_PC4;
                rf_we_o  = 1'b1;
            end
            OPC_BRANCH: begin
                pc_sel_o = br_taken ? PC_BR : PC_PLUS4;
            end
            OPC_OP_IMM: begin
                alu_op_o  = arith_op;
                op2_sel_o = OP2_IMM_I;
                rf_we_o   = 1'b1;
            end
            OPC_OP: begin
                alu_op_o = arith_op;
                rf_we_o  = 1'b1;
            end
            // SYSTEM and unknown opcodes retire as no-ops
            default: ;
        endcase
    end

    // Only the exact EBREAK word halts, ECALL and CSR forms do not
    assign halt_req_o = (inst_i == EBREAK_INST);

endmodule

`default_nettype wire

/* src/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit import core_pkg::*; (
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  op1_sel_t  op1_sel_i,
    input  op2_sel_t  op2_sel_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_addr_o,
    output xlen_t     op_a_o,
    output xlen_t     op_b_o,
    output xlen_t     br_target_o,
    output xlen_t     jal_target_o,
    output xlen_t     jalr_target_o,
    output logic      br_eq_o,
    output logic      br_lt_o,
    output logic      br_ltu_o
);

    xlen_t imm_i;
    xlen_t imm_b;
    xlen_t imm_j;
    xlen_t imm_u;

    // Register fields sit at fixed positions in every format
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Sign-extended immediates, bit 31 is always the sign
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // Operand A
    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op_a_o = pc_i;
            OP1_ZERO: op_a_o = '0;
            default:  op_a_o = rs1_data_i;
        endcase
    end

    // Operand B, shift amounts come from the low bits of imm_i
    always_comb begin
        case (op2_sel_i)
            OP2_IMM_I: op_b_o = imm_i;
            OP2_IMM_U: op_b_o = imm_u;
            default:   op_b_o = rs2_data_i;
        endcase
    end

    // Jump and branch targets
    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    assign jalr_target_o = rs1_data_i + imm_i;

    // Comparison flags for branch resolution
    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      we_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  xlen_t     wd_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output xlen_t     x1_o,
    output xlen_t     x2_o,
    output xlen_t     x3_o
);

    // Entry 0 is never written and reads of x0 are forced to zero below
    xlen_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= wd_i;
        end
    end

    // Combinational reads see the value from before this cycle's write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // Debug taps
    assign x1_o = regs[1];
    assign x2_o = regs[2];
    assign x3_o = regs[3];

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  pc_sel_t pc_sel_i,
    input  xlen_t   br_target_i,
    input  xlen_t   jal_target_i,
    input  xlen_t   jalr_target_i,
    input  logic    halt_req_i,
    output xlen_t   pc_o,
    output logic    halted_o
);

    xlen_t pc_next;

    // Next PC, JALR drops bit 0 of its sum as the ISA requires
    always_comb begin
        case (pc_sel_i)
            PC_BR:   pc_next = br_target_i;
            PC_JAL:  pc_next = jal_target_i;
            PC_JALR: pc_next = {jalr_target_i[XLEN-1:1], 1'b0};
            default: pc_next = pc_o + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o     <= RESET_PC;
            halted_o <= 1'b0;
        end else begin
            // Sticky until reset
            if (halt_req_i) begin
                halted_o <= 1'b1;
            end
            // PC freezes on the EBREAK itself and stays there
            if (!halted_o && !halt_req_i) begin
                pc_o <= pc_next;
            end
        end
    end

    pc_aligned_a: assert property (
        @(posedge clk) disable iff (reset_i) pc_o[1:0] == 2'b00
    ) else $error("pc_o misaligned: %h", pc_o);

    pc_frozen_a: assert property (
        @(posedge clk) disable iff (reset_i) halted_o |=> $stable(pc_o)
    ) else $error("pc_o moved while halted: %h", pc_o);

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ALU operations, PASS_B feeds the U-immediate straight through for LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2   = 2'd0,
        OP2_IMM_I = 2'd1,
        OP2_IMM_U = 2'd2
    } op2_sel_t;

    typedef enum logic [1:0] {
        PC_PLUS4 = 2'd0,
        PC_BR    = 2'd1,
        PC_JAL   = 2'd2,
        PC_JALR  = 2'd3
    } pc_sel_t;

    typedef enum logic {
        WB_ALU   = 1'b0,
        WB_PC4   = 1'b1
    } wb_sel_t;

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    localparam xlen_t RESET_PC    = 32'h0000_0000;
    localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire
